/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

    // width of PCs, addresses and data words
    localparam int xlen = 32;

    // major opcodes of 32-bit control transfers
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    // low two bits of compressed words, 2'b11 marks a 32-bit instruction
    localparam logic [1:0] c_quadrant1 = 2'b01;
    localparam logic [1:0] c_quadrant2 = 2'b10;

    // funct3 values in quadrant 1
    localparam logic [2:0] c_funct_jal  = 3'b001;
    localparam logic [2:0] c_funct_j    = 3'b101;
    localparam logic [2:0] c_funct_beqz = 3'b110;
    localparam logic [2:0] c_funct_bnez = 3'b111;

    // funct3 in quadrant 2 shared by c.jr, c.mv, c.jalr, c.add and c.ebreak
    localparam logic [2:0] c_funct_jr = 3'b100;

endpackage

/* rtl/fetch_cfg_pkg.sv */
package fetch_cfg_pkg;

    // one 32-bit word per line
    localparam int icache_lines = 32;

    // lines are indexed by PC bits 5 to 1, one line per halfword slot
    localparam int index_bits = 5;

    // tag is taken from PC bits 31 to 5
    localparam int tag_bits = 27;

    // first fetch address after reset
    localparam logic [31:0] reset_pc = 32'h0000_0000;

endpackage

/* rtl/next_pc_predict.sv */
`timescale 1ns/1ps

module next_pc_predict (
    input  logic [rv_isa_pkg::xlen-1:0] pc,
    input  logic [rv_isa_pkg::xlen-1:0] word,
    output logic [rv_isa_pkg::xlen-1:0] pred_next_pc,
    output logic                        pred_compressed,
    output logic                        pred_stop
);
    import rv_isa_pkg::*;

    logic [xlen-1:0] imm_jal;
    logic [xlen-1:0] imm_branch;
    logic [xlen-1:0] imm_cj;
    logic [xlen-1:0] imm_cb;
    logic [xlen-1:0] seq_pc;
    logic [2:0]      c_funct;

    assign pred_compressed = (word[1:0] != 2'b11);
    assign c_funct         = word[15:13];
    assign seq_pc          = pc + (pred_compressed ? xlen'(2) : xlen'(4));

    // immediates with the bit scrambling of each format undone
    assign imm_jal = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};

    assign imm_branch = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};

    assign imm_cj = {{20{word[12]}}, word[12], word[8], word[10:9], word[6], word[7],
                     word[2], word[11], word[5:3], 1'b0};

    assign imm_cb = {{23{word[12]}}, word[12], word[6:5], word[2], word[11:10],
                     word[4:3], 1'b0};

    always_comb begin
        pred_next_pc = seq_pc;
        pred_stop    = 1'b0;
        if (!pred_compressed) begin
            case (word[6:0])
                op_jal: begin
                    pred_next_pc = pc + imm_jal;
                end
                op_branch: begin
                    // conditional branches are always predicted taken
                    pred_next_pc = pc + imm_branch;
                end
                op_jalr: begin
                    pred_stop = 1'b1;
                end
                default: begin
                    pred_next_pc = seq_pc;
                end
            endcase
        end else if (word[1:0] == c_quadrant1) begin
            case (c_funct)
                c_funct_jal, c_funct_j: begin
                    pred_next_pc = pc + imm_cj;
                end
                c_funct_beqz, c_funct_bnez: begin
                    pred_next_pc = pc + imm_cb;
                end
                default: begin
                    pred_next_pc = seq_pc;
                end
            endcase
        end else if (word[1:0] == c_quadrant2 && c_funct == c_funct_jr) begin
            // c.jr and c.jalr have rs2 zero and a nonzero rs1
            if (word[6:2] == 5'd0 && word[11:7] != 5'd0) begin
                pred_stop = 1'b1;
            end
        end
    end

endmodule

/* rtl/icache.sv */
`timescale 1ns/1ps

module icache (
    input  logic        clk,
    input  logic        rst,
    input  logic        lookup,
    input  logic [31:0] lookup_pc,
    output logic        hit_valid,
    output logic [31:0] hit_data,
    output logic        refill_req,
    output logic [31:0] refill_addr,
    input  logic        refill_done,
    input  logic [31:0] refill_data
);
    import fetch_cfg_pkg::*;

    logic [icache_lines-1:0] line_valid;
    logic [tag_bits-1:0]     tag_mem [icache_lines];
    logic [31:0]             data_mem [icache_lines];
    logic [index_bits-1:0]   index;
    logic [tag_bits-1:0]     tag;
    logic                    hit_r;
    logic [31:0]             hit_word_r;
    logic [index_bits-1:0]   miss_index;
    logic [tag_bits-1:0]     miss_tag;
    logic                    miss_upper;
    logic [31:0]             refill_view;

    assign index = lookup_pc[index_bits:1];
    assign tag   = lookup_pc[31 -: tag_bits];

    // a fetch at offset 2 sees the upper halfword moved down
    assign refill_view = miss_upper ? {16'h0000, refill_data[31:16]} : refill_data;

    // the refilled word goes straight out in the cycle it is written
    assign hit_valid = hit_r | refill_done;
    assign hit_data  = refill_done ? refill_view : hit_word_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            line_valid <= '0;
            hit_r      <= 1'b0;
            refill_req <= 1'b0;
        end else begin
            hit_r      <= 1'b0;
            refill_req <= 1'b0;
            if (lookup) begin
                if (line_valid[index] && tag_mem[index] == tag) begin
                    hit_r <= 1'b1;
                end else begin
                    refill_req <= 1'b1;
                end
            end
            if (refill_done) begin
                line_valid[miss_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup) begin
            hit_word_r  <= lookup_pc[1] ? {16'h0000, data_mem[index][31:16]} : data_mem[index];
            miss_index  <= index;
            miss_tag    <= tag;
            miss_upper  <= lookup_pc[1];
            refill_addr <= {lookup_pc[31:2], 2'b00};
        end
        if (refill_done) begin
            tag_mem[miss_index]  <= miss_tag;
            data_mem[miss_index] <= refill_data;
        end
    end

endmodule

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic        clk,
    input  logic        rst,
    input  logic        iq_full,
    input  logic        lsb_full,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    output logic        lookup,
    output logic [31:0] lookup_pc,
    input  logic        hit_valid,
    input  logic [31:0] hit_data,
    output logic        inst_valid,
    output logic [31:0] inst_data,
    output logic [31:0] inst_pc,
    output logic        inst_compressed
);
    import fetch_cfg_pkg::*;

    typedef enum logic [1:0] {st_idle, st_wait, st_stop, st_discard} state_t;

    state_t      state;
    logic [31:0] pc;
    logic        stall;
    logic [31:0] pred_next_pc;
    logic        pred_compressed;
    logic        pred_stop;

    next_pc_predict u_predict (
        .pc              (pc),
        .word            (hit_data),
        .pred_next_pc    (pred_next_pc),
        .pred_compressed (pred_compressed),
        .pred_stop       (pred_stop)
    );

    assign stall     = iq_full | lsb_full;
    assign lookup_pc = pc;

    // a word arriving with a redirect belongs to the wrong path
    assign inst_valid      = hit_valid && state == st_wait && !redirect;
    assign inst_data       = pred_compressed ? {16'h0000, hit_data[15:0]} : hit_data;
    assign inst_pc         = pc;
    assign inst_compressed = pred_compressed;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= st_idle;
            pc     <= reset_pc;
            lookup <= 1'b0;
        end else begin
            lookup <= 1'b0;
            if (redirect) begin
                pc <= redirect_pc;
            end
            case (state)
                st_idle: begin
                    if (!redirect && !stall) begin
                        lookup <= 1'b1;
                        state  <= st_wait;
                    end
                end
                st_wait: begin
                    if (redirect) begin
                        state <= hit_valid ? st_idle : st_discard;
                    end else if (hit_valid) begin
                        pc <= pred_next_pc;
                        if (pred_stop) begin
                            state <= st_stop;
                        end else if (stall) begin
                            state <= st_idle;
                        end else begin
                            // back-to-back lookup at the predicted PC
                            lookup <= 1'b1;
                        end
                    end
                end
                st_stop: begin
                    if (redirect) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    // wait out the stale refill, it still fills the cache
                    if (hit_valid) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

endmodule

/* rtl/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic        clk,
    input  logic        rst,
    input  logic        data_req,
    input  logic [31:0] data_addr,
    input  logic        data_we,
    input  logic [31:0] data_wdata,
    output logic        data_done,
    output logic [31:0] data_rdata,
    input  logic        refill_req,
    input  logic [31:0] refill_addr,
    output logic        refill_done,
    output logic [31:0] refill_data,
    output logic        mem_req,
    output logic [31:0] mem_addr,
    output logic        mem_we,
    output logic [31:0] mem_wdata,
    input  logic        mem_valid,
    input  logic [31:0] mem_rdata
);
    logic        data_pend;
    logic [31:0] data_addr_q;
    logic        data_we_q;
    logic [31:0] data_wdata_q;
    logic        refill_pend;
    logic [31:0] refill_addr_q;
    logic        busy;
    logic        owner_refill;

    always_ff @(posedge clk) begin
        if (rst) begin
            data_pend    <= 1'b0;
            refill_pend  <= 1'b0;
            busy         <= 1'b0;
            owner_refill <= 1'b0;
            mem_req      <= 1'b0;
            data_done    <= 1'b0;
            refill_done  <= 1'b0;
        end else begin
            mem_req     <= 1'b0;
            data_done   <= 1'b0;
            refill_done <= 1'b0;
            if (!busy && data_pend) begin
                busy         <= 1'b1;
                owner_refill <= 1'b0;
                mem_req      <= 1'b1;
                data_pend    <= 1'b0;
            end else if (!busy && refill_pend) begin
                busy         <= 1'b1;
                owner_refill <= 1'b1;
                mem_req      <= 1'b1;
                refill_pend  <= 1'b0;
            end
            if (busy && mem_valid) begin
                busy        <= 1'b0;
                data_done   <= !owner_refill;
                refill_done <= owner_refill;
            end
            // new requests are latched last so a same-cycle clear does not drop them
            if (data_req) begin
                data_pend <= 1'b1;
            end
            if (refill_req) begin
                refill_pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_req) begin
            data_addr_q  <= data_addr;
            data_we_q    <= data_we;
            data_wdata_q <= data_wdata;
        end
        if (refill_req) begin
            refill_addr_q <= refill_addr;
        end
        if (!busy && data_pend) begin
            mem_addr  <= data_addr_q;
            mem_we    <= data_we_q;
            mem_wdata <= data_wdata_q;
        end else if (!busy && refill_pend) begin
            mem_addr  <= refill_addr_q;
            mem_we    <= 1'b0;
            mem_wdata <= '0;
        end
        if (busy && mem_valid) begin
            data_rdata  <= mem_rdata;
            refill_data <= mem_rdata;
        end
    end

endmodule

/* rtl/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
    input  logic        clk,
    input  logic        rst,
    output logic        inst_valid,
    output logic [31:0] inst_data,
    output logic [31:0] inst_pc,
    output logic        inst_compressed,
    input  logic        iq_full,
    input  logic        lsb_full,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    input  logic        data_req,
    input  logic [31:0] data_addr,
    input  logic        data_we,
    input  logic [31:0] data_wdata,
    output logic        data_done,
    output logic [31:0] data_rdata,
    output logic        mem_req,
    output logic [31:0] mem_addr,
    output logic        mem_we,
    output logic [31:0] mem_wdata,
    input  logic        mem_valid,
    input  logic [31:0] mem_rdata
);
    logic        lookup;
    logic [31:0] lookup_pc;
    logic        hit_valid;
    logic [31:0] hit_data;
    logic        refill_req;
    logic [31:0] refill_addr;
    logic        refill_done;
    logic [31:0] refill_data;

    fetch_unit u_fetch (
        .clk             (clk),
        .rst             (rst),
        .iq_full         (iq_full),
        .lsb_full        (lsb_full),
        .redirect        (redirect),
        .redirect_pc     (redirect_pc),
        .lookup          (lookup),
        .lookup_pc       (lookup_pc),
        .hit_valid       (hit_valid),
        .hit_data        (hit_data),
        .inst_valid      (inst_valid),
        .inst_data       (inst_data),
        .inst_pc         (inst_pc),
        .inst_compressed (inst_compressed)
    );

    icache u_icache (
        .clk         (clk),
        .rst         (rst),
        .lookup      (lookup),
        .lookup_pc   (lookup_pc),
        .hit_valid   (hit_valid),
        .hit_data    (hit_data),
        .refill_req  (refill_req),
        .refill_addr (refill_addr),
        .refill_done (refill_done),
        .refill_data (refill_data)
    );

    mem_arbiter u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .data_req    (data_req),
        .data_addr   (data_addr),
        .data_we     (data_we),
        .data_wdata  (data_wdata),
        .data_done   (data_done),
        .data_rdata  (data_rdata),
        .refill_req  (refill_req),
        .refill_addr (refill_addr),
        .refill_done (refill_done),
        .refill_data (refill_data),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_we      (mem_we),
        .mem_wdata   (mem_wdata),
        .mem_valid   (mem_valid),
        .mem_rdata   (mem_rdata)
    );

endmodule

/* verification/fetch_assertions.sv */
`timescale 1ns/1ps

module fetch_assertions (
    input logic clk,
    input logic rst,
    input logic mem_req,
    input logic mem_valid,
    input logic data_done,
    input logic refill_done,
    input logic inst_valid,
    input logic pred_stop,
    input logic redirect
);

    int   fail_count = 0;
    logic outstanding;
    logic stopped;

    // an access is outstanding from mem_req until the memory answers
    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (mem_req) begin
            outstanding <= 1'b1;
        end else if (mem_valid) begin
            outstanding <= 1'b0;
        end
    end

    // fetch stops once an indirect jump is delivered and resumes on redirect
    always_ff @(posedge clk) begin
        if (rst) begin
            stopped <= 1'b0;
        end else if (redirect) begin
            stopped <= 1'b0;
        end else if (inst_valid && pred_stop) begin
            stopped <= 1'b1;
        end
    end

    a_single_access: assert property (@(posedge clk) disable iff (rst)
        mem_req |-> !outstanding)
        else begin
            $error("memory request issued while an access is outstanding");
            fail_count = fail_count + 1;
        end

    a_one_done: assert property (@(posedge clk) disable iff (rst)
        !(data_done && refill_done))
        else begin
            $error("data and refill responses completed together");
            fail_count = fail_count + 1;
        end

    a_no_fetch_when_stopped: assert property (@(posedge clk) disable iff (rst)
        stopped |-> !inst_valid)
        else begin
            $error("instruction delivered while fetch is stopped");
            fail_count = fail_count + 1;
        end

endmodule

bind mem_arbiter fetch_assertions arbiter_checks (
    .clk(clk), .rst(rst), .mem_req(mem_req), .mem_valid(mem_valid), .data_done(data_done),
    .refill_done(refill_done), .inst_valid(1'b0), .pred_stop(1'b0), .redirect(1'b0)
);

bind fetch_unit fetch_assertions fetch_checks (
    .clk(clk), .rst(rst), .mem_req(1'b0), .mem_valid(1'b0), .data_done(1'b0),
    .refill_done(1'b0), .inst_valid(inst_valid), .pred_stop(pred_stop), .redirect(redirect)
);

/* verification/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb;
    import rv_isa_pkg::*;
    import fetch_cfg_pkg::*;

    localparam int num_tests = 6;
    localparam int mem_words = 4096;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        inst_valid;
    logic [31:0] inst_data;
    logic [31:0] inst_pc;
    logic        inst_compressed;
    logic        iq_full = 1'b0;
    logic        lsb_full = 1'b0;
    logic        redirect = 1'b0;
    logic [31:0] redirect_pc = '0;
    logic        data_req = 1'b0;
    logic [31:0] data_addr = '0;
    logic        data_we = 1'b0;
    logic [31:0] data_wdata = '0;
    logic        data_done;
    logic [31:0] data_rdata;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        mem_we;
    logic [31:0] mem_wdata;
    logic        mem_valid = 1'b0;
    logic [31:0] mem_rdata = '0;

    logic [31:0] mem [mem_words];
    logic [31:0] stored [16];
    logic [31:0] lcg_state = 32'd15370;
    logic [31:0] q_pc [$];
    logic [31:0] q_data [$];
    logic        q_comp [$];
    int          mem_req_count = 0;
    int          mem_cnt = 0;
    logic [31:0] m_addr;
    logic        m_we;
    logic [31:0] m_wdata;
    logic        stall_done;

    fetch_top DUT (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {17'd0, lcg_state[30:16]};
    endfunction

    // memory answers after 1 to 4 cycles, one access at a time
    always @(posedge clk) begin
        mem_valid <= 1'b0;
        if (mem_req) begin
            mem_req_count = mem_req_count + 1;
            mem_cnt = int'(next_rand() % 32'd4) + 1;
            m_addr = mem_addr;
            m_we = mem_we;
            m_wdata = mem_wdata;
        end else if (mem_cnt > 0) begin
            mem_cnt = mem_cnt - 1;
            if (mem_cnt == 0) begin
                mem_valid <= 1'b1;
                mem_rdata <= mem[m_addr[13:2]];
                if (m_we) begin
                    mem[m_addr[13:2]] = m_wdata;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && inst_valid) begin
            q_pc.push_back(inst_pc);
            q_data.push_back(inst_data);
            q_comp.push_back(inst_compressed);
        end
    end

    initial begin
        repeat (num_tests * 2000) @(posedge clk);
        $display("timeout: the tests did not complete in time");
        fail_run();
    end

    function automatic logic [31:0] enc_addi(logic [11:0] imm);
        return {imm, 5'd0, 3'b000, 5'd1, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_jal(logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd0, op_jal};
    endfunction

    function automatic logic [31:0] enc_beq(logic [12:0] off);
        return {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], op_branch};
    endfunction

    function automatic logic [15:0] enc_cj(logic [2:0] f, logic [11:0] off);
        return {f, off[11], off[4], off[9:8], off[10], off[6], off[7], off[3:1], off[5],
                c_quadrant1};
    endfunction

    function automatic logic [15:0] enc_cb(logic [2:0] f, logic [8:0] off);
        return {f, off[8], off[4:3], 3'd0, off[7:6], off[2:1], off[5], c_quadrant1};
    endfunction

    // the instruction at pc as the backend should see it
    function automatic logic [31:0] fetch_word(logic [31:0] pc);
        logic [31:0] w;
        w = mem[pc[13:2]];
        if (pc[1]) begin
            w = {16'h0000, w[31:16]};
        end
        if (w[1:0] != 2'b11) begin
            w = {16'h0000, w[15:0]};
        end
        return w;
    endfunction

    function automatic logic [31:0] ref_next(input logic [31:0] pc, input logic [31:0] w,
                                             output logic stop);
        logic [31:0] nxt;
        stop = 1'b0;
        if (w[1:0] == 2'b11) begin
            nxt = pc + 32'd4;
            if (w[6:0] == op_jal) begin
                nxt = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end else if (w[6:0] == op_branch) begin
                nxt = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end else if (w[6:0] == op_jalr) begin
                stop = 1'b1;
            end
        end else begin
            nxt = pc + 32'd2;
            if (w[1:0] == c_quadrant1 && (w[15:13] == c_funct_j || w[15:13] == c_funct_jal)) begin
                nxt = pc + {{21{w[12]}}, w[8], w[10:9], w[6], w[7], w[2], w[11], w[5:3], 1'b0};
            end else if (w[1:0] == c_quadrant1 && w[15:14] == 2'b11) begin
                nxt = pc + {{24{w[12]}}, w[6:5], w[2], w[11:10], w[4:3], 1'b0};
            end else if (w[1:0] == c_quadrant2 && w[15:13] == c_funct_jr &&
                         w[6:2] == 5'd0 && w[11:7] != 5'd0) begin
                stop = 1'b1;
            end
        end
        return nxt;
    endfunction

    // number of instructions up to and including the first indirect jump
    function automatic int ref_length(logic [31:0] start);
        logic [31:0] pc;
        logic        stop;
        int          n;
        pc = start;
        n = 0;
        stop = 1'b0;
        while (!stop && n < 64) begin
            pc = ref_next(pc, fetch_word(pc), stop);
            n = n + 1;
        end
        return n;
    endfunction

    task automatic put32(logic [31:0] addr, logic [31:0] w);
        mem[addr[13:2]] = w;
    endtask

    task automatic put16(logic [31:0] addr, logic [15:0] h);
        if (addr[1]) begin
            mem[addr[13:2]][31:16] = h;
        end else begin
            mem[addr[13:2]][15:0] = h;
        end
    endtask

    task automatic fail_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped after an error");
    endtask

    task automatic check_pc(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s pc expected %h actual %h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_inst(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s inst expected %h actual %h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_compressed(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("CHECK FAILED %s compressed expected %b actual %b", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_data(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s data expected %h actual %h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic apply_reset();
        rst <= 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    endtask

    // the stream is cleared once the pulse is seen, nothing older can follow
    task automatic redirect_to(logic [31:0] pc);
        @(posedge clk);
        redirect <= 1'b1;
        redirect_pc <= pc;
        @(posedge clk);
        redirect <= 1'b0;
        q_pc.delete();
        q_data.delete();
        q_comp.delete();
    endtask

    task automatic run_expect(string name, logic [31:0] start, int n, bit quiet);
        logic [31:0] pc;
        logic [31:0] w;
        logic        stop;
        while (q_pc.size() < n) @(posedge clk);
        pc = start;
        for (int i = 0; i < n; i++) begin
            w = fetch_word(pc);
            check_pc(name, pc, q_pc[i]);
            check_inst(name, w, q_data[i]);
            check_compressed(name, w[1:0] != 2'b11, q_comp[i]);
            pc = ref_next(pc, w, stop);
        end
        if (quiet) begin
            repeat (20) @(posedge clk);
            check_data(name, 32'(n), 32'(q_pc.size()));
        end
    endtask

    task automatic data_op(string name, logic [31:0] addr, logic we, logic [31:0] wdata);
        @(posedge clk);
        data_req <= 1'b1;
        data_addr <= addr;
        data_we <= we;
        data_wdata <= wdata;
        @(posedge clk);
        data_req <= 1'b0;
        @(posedge clk);
        while (!data_done) @(posedge clk);
        if (we) begin
            stored[addr[5:2]] = wdata;
        end else begin
            check_data(name, stored[addr[5:2]], data_rdata);
        end
    endtask

    task automatic test_straight();
        put32(32'h00, enc_addi(12'd11));
        put16(32'h04, 16'h0085);
        put16(32'h06, 16'h0001);
        put32(32'h08, enc_addi(12'd12));
        put16(32'h0c, 16'h0085);
        put16(32'h0e, 16'h0089);
        put32(32'h10, enc_addi(12'd13));
        put32(32'h14, 32'h00008067);
        apply_reset();
        run_expect("straight", reset_pc, ref_length(reset_pc), 1'b1);
    endtask

    task automatic test_predict();
        put32(32'h100, enc_jal(21'd8));
        put32(32'h108, enc_beq(13'd8));
        put16(32'h110, enc_cj(c_funct_j, 12'd6));
        put16(32'h116, enc_cj(c_funct_jal, 12'd6));
        put16(32'h11c, enc_cb(c_funct_beqz, 9'd4));
        put16(32'h120, enc_cb(c_funct_bnez, 9'd8));
        put32(32'h128, enc_jal(21'd16));
        put32(32'h130, enc_addi(12'd21));
        put32(32'h134, 32'h00008067);
        // backward branch to 0x130
        put32(32'h138, enc_beq(13'h1ff8));
        redirect_to(32'h100);
        run_expect("predict", 32'h100, ref_length(32'h100), 1'b1);
    endtask

    task automatic test_indirect();
        put32(32'h200, enc_addi(12'd31));
        put16(32'h204, 16'h0085);
        put16(32'h206, 16'h8082);
        put32(32'h280, enc_addi(12'd32));
        put32(32'h284, 32'h00008067);
        redirect_to(32'h200);
        run_expect("indirect", 32'h200, ref_length(32'h200), 1'b1);
        redirect_to(32'h280);
        run_expect("indirect", 32'h280, ref_length(32'h280), 1'b1);
    endtask

    task automatic test_loop();
        int snap;
        put32(32'h300, enc_addi(12'd41));
        put16(32'h304, 16'h0085);
        put16(32'h306, 16'h0089);
        put32(32'h308, enc_addi(12'd42));
        put32(32'h30c, enc_beq(13'h1ff4));
        put32(32'h340, 32'h00008067);
        redirect_to(32'h300);
        while (q_pc.size() < 5) @(posedge clk);
        snap = mem_req_count;
        run_expect("loop", 32'h300, 15, 1'b0);
        check_data("loop", 32'(snap), 32'(mem_req_count));
        redirect_to(32'h340);
        run_expect("loop", 32'h340, 1, 1'b1);
    endtask

    task automatic test_shared();
        logic [31:0] v;
        for (int i = 0; i < 10; i++) begin
            put32(32'h400 + 32'(4 * i), enc_addi(12'(50 + i)));
        end
        put32(32'h428, 32'h00008067);
        fork
            begin
                redirect_to(32'h400);
                run_expect("shared", 32'h400, ref_length(32'h400), 1'b1);
            end
            begin
                for (int i = 0; i < 4; i++) begin
                    v = next_rand() ^ 32'(i << 20);
                    data_op("shared", 32'h2000 + 32'(4 * i), 1'b1, v);
                end
                data_op("shared", 32'h2004, 1'b1, 32'hcafe_0104);
                for (int i = 0; i < 4; i++) begin
                    data_op("shared", 32'h2000 + 32'(4 * i), 1'b0, 32'h0);
                end
            end
        join
    endtask

    task automatic test_stall_flush();
        logic [31:0] r;
        put32(32'h500, enc_addi(12'd61));
        put16(32'h504, 16'h0085);
        put16(32'h506, 16'h0089);
        put32(32'h508, enc_jal(21'd8));
        put32(32'h510, enc_addi(12'd62));
        put16(32'h514, 16'h0085);
        put16(32'h516, 16'h0001);
        put32(32'h518, enc_addi(12'd63));
        put32(32'h51c, 32'h00008067);
        put32(32'h600, enc_addi(12'd64));
        put16(32'h604, 16'h0085);
        put16(32'h606, 16'h8082);
        stall_done = 1'b0;
        fork
            begin
                redirect_to(32'h500);
                run_expect("stall", 32'h500, ref_length(32'h500), 1'b1);
                stall_done = 1'b1;
            end
            begin
                while (!stall_done) begin
                    @(posedge clk);
                    r = next_rand();
                    iq_full <= (r[1:0] == 2'd0);
                    lsb_full <= (r[4:2] == 3'd0);
                end
                iq_full <= 1'b0;
                lsb_full <= 1'b0;
            end
        join
        // the line at 0x5c0 is cold, so the redirect lands on a pending miss
        redirect_to(32'h5c0);
        @(posedge clk);
        while (!mem_req) @(posedge clk);
        redirect_to(32'h600);
        run_expect("flush", 32'h600, ref_length(32'h600), 1'b1);
    endtask

    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = enc_addi(12'(i));
        end
        test_straight();
        test_predict();
        test_indirect();
        test_loop();
        test_shared();
        test_stall_flush();
        if (DUT.u_arbiter.arbiter_checks.fail_count == 0 &&
                DUT.u_fetch.fetch_checks.fail_count == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            fail_run();
        end
    end

endmodule

/* flist.f */
rtl/rv_isa_pkg.sv
rtl/fetch_cfg_pkg.sv
rtl/next_pc_predict.sv
rtl/icache.sv
rtl/fetch_unit.sv
rtl/mem_arbiter.sv
rtl/fetch_top.sv
verification/fetch_assertions.sv
verification/fetch_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= fetch_tb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "Simulation finished: FAIL" $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
